//--- hw/chan_cfg_bank.sv
// Channel configuration bank
// One byte register per channel, written under the mask, stalled by hold
`default_nettype none

module chan_cfg_bank
	import cmd_pkg::*;
(
	input  wire logic                  clk,
	input  wire logic                  rst_n,
	input  wire logic                  data_valid,
	input  wire logic [7:0]            cmd_mask,
	input  wire logic [7:0]            data,
	input  wire logic                  hold,
	output logic                       data_ack,
	output logic      [NUM_CHAN*8-1:0] cfg
);

	// Accept regardless of mask so zero-mask frames still drain
	assign data_ack = data_valid && !hold;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			cfg <= '0;
		else if (data_ack)
		begin
			for (int i = 0; i < NUM_CHAN; i++)
			begin
				if (cmd_mask[i])
					cfg[i*8 +: 8] <= data;    // Channel i byte
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/cmd_fifo.sv
// Single-clock byte FIFO
// Show-ahead read port, fill count, writes to a full FIFO are dropped
`default_nettype none

module cmd_fifo
	import cmd_pkg::*;
(
	input  wire logic               clk,
	input  wire logic               rst_n,
	input  wire logic               wr,
	input  wire logic [7:0]         wdata,
	input  wire logic               rd_req,
	output logic      [7:0]         q,
	output logic                    empty,
	output logic      [FIFO_AW:0]   used
);

	logic [7:0]         mem [0:FIFO_DEPTH-1];
	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	logic [FIFO_AW:0]   count;
	logic               full;
	logic               do_wr;
	logic               do_rd;

	assign full  = (count == (FIFO_AW+1)'(FIFO_DEPTH));
	assign empty = (count == '0);
	assign used  = count;

	assign do_wr = wr && !full;
	assign do_rd = rd_req && !empty;    // Pop on empty is ignored

	// Head byte always visible
	assign q = mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (do_wr)
			mem[wr_ptr] <= wdata;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;    // Wraps at depth
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;

			// Simultaneous push and pop leaves the count alone
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hw/cmd_parser_fsm.sv
// Command frame parser
// Finds the magic byte, checks the length, waits for the whole frame,
// then hands data bytes with the mask to the channel bank
`default_nettype none

module cmd_parser_fsm
	import cmd_pkg::*;
(
	input  wire logic               clk,
	input  wire logic               rst_n,
	input  wire logic [7:0]         q,
	input  wire logic               empty,
	input  wire logic [FIFO_AW:0]   used,
	output logic                    rd_req,
	output logic                    tmr_load,
	output logic                    tmr_run,
	input  wire logic               tmr_expired,
	output logic                    data_valid,
	output logic      [7:0]         cmd_mask,
	output logic      [7:0]         data,
	input  wire logic               data_ack,
	output logic                    cmd_done,
	output logic                    cmd_abort,
	output parser_state_t           state
);

	logic [FIFO_AW:0] len;       // Data bytes after the mask
	logic [FIFO_AW:0] need;      // Mask plus data
	logic [FIFO_AW:0] remain;
	logic [7:0]       mask;
	logic             len_ok;
	logic             frame_in;
	logic             consume;

	assign len_ok   = (q <= 8'(MAX_CMD_LEN));
	assign need     = len + 1'b1;
	assign frame_in = (used >= need);

	assign data_valid = (state == ST_SEND) && (remain != '0);
	assign consume    = data_valid && data_ack;
	assign cmd_mask   = data_valid ? mask : 8'h00;
	assign data       = q;

	// Timer only counts while the frame is still arriving
	assign tmr_load = (state == ST_LEN) && !empty && len_ok;
	assign tmr_run  = (state == ST_WAIT);

	always_comb
	begin
		case (state)
			ST_IDLE: rd_req = !empty;        // Discard until magic
			ST_LEN:  rd_req = !empty;
			ST_WAIT: rd_req = frame_in;      // Mask byte
			ST_SEND: rd_req = consume;
			default: rd_req = 1'b0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (ST_WAIT == state && frame_in)
			mask <= q;
		if (ST_LEN == state && !empty)
			len <= q[FIFO_AW:0];
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state     <= ST_IDLE;
			remain    <= '0;
			cmd_done  <= 1'b0;
			cmd_abort <= 1'b0;
		end
		else
		begin
			cmd_done  <= 1'b0;
			cmd_abort <= 1'b0;

			case (state)
				ST_IDLE:
					if (!empty && q == CMD_MAGIC)
						state <= ST_LEN;

				ST_LEN:
					if (!empty)
					begin
						if (len_ok)
							state <= ST_WAIT;
						else
						begin
							// Could never fit in the FIFO
							state     <= ST_IDLE;
							cmd_abort <= 1'b1;
						end
					end

				ST_WAIT:
					if (frame_in)
					begin
						remain <= len;
						state  <= ST_SEND;
					end
					else if (tmr_expired)
					begin
						state     <= ST_IDLE;
						cmd_abort <= 1'b1;
					end

				ST_SEND:
					if (remain == '0)
					begin
						state    <= ST_IDLE;
						cmd_done <= 1'b1;
					end
					else if (consume)
						remain <= remain - 1'b1;    // Held while hold is high

				default:
					state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hw/cmd_pkg.sv
// Shared constants for the command subsystem
// Frame magic, FIFO sizing, length and timeout limits, channel count
// Parser state encoding
`default_nettype none

package cmd_pkg;

	// Frame format
	localparam logic [7:0] CMD_MAGIC = 8'hAA;
	localparam int MAX_CMD_LEN = 63;    // Largest data length per frame

	// Command FIFO
	localparam int FIFO_DEPTH = 64;
	localparam int FIFO_AW = 6;         // Fill count is FIFO_AW+1 bits

	// Cycles to wait for the rest of a frame
	localparam int RECV_TIMEOUT = 255;

	// Channel bank, one mask bit per channel
	localparam int NUM_CHAN = 8;

	typedef enum logic [1:0]
	{
		ST_IDLE = 2'd0,   // Hunting for magic byte
		ST_LEN  = 2'd1,   // Length byte
		ST_WAIT = 2'd2,   // Frame still arriving
		ST_SEND = 2'd3    // Data bytes out to bank
	} parser_state_t;

endpackage

`default_nettype wire

//--- hw/cmd_subsys_top.sv
// Command subsystem top level
// Byte FIFO, receive timer, frame parser and channel bank
`default_nettype none

module cmd_subsys_top
	import cmd_pkg::*;
(
	input  wire logic                  clk,
	input  wire logic                  rst_n,
	input  wire logic [7:0]            cmd_in,
	input  wire logic                  cmd_wr,
	input  wire logic                  hold,
	output logic      [NUM_CHAN*8-1:0] cfg,
	output logic                       cmd_done,
	output logic                       cmd_abort,
	output parser_state_t              parser_state
);

	// FIFO read side
	logic [7:0]       fifo_q;
	logic             fifo_empty;
	logic [FIFO_AW:0] fifo_used;
	logic             rd_req;

	// Timer control
	logic tmr_load;
	logic tmr_run;
	logic tmr_expired;

	// Parser to bank
	logic       data_valid;
	logic [7:0] cmd_mask;
	logic [7:0] data;
	logic       data_ack;

	cmd_fifo u_fifo (
		.clk    (clk),
		.rst_n  (rst_n),
		.wr     (cmd_wr),
		.wdata  (cmd_in),
		.rd_req (rd_req),
		.q      (fifo_q),
		.empty  (fifo_empty),
		.used   (fifo_used)
	);

	recv_timer u_timer (
		.clk     (clk),
		.rst_n   (rst_n),
		.load    (tmr_load),
		.run     (tmr_run),
		.expired (tmr_expired)
	);

	cmd_parser_fsm u_parser (
		.clk         (clk),
		.rst_n       (rst_n),
		.q           (fifo_q),
		.empty       (fifo_empty),
		.used        (fifo_used),
		.rd_req      (rd_req),
		.tmr_load    (tmr_load),
		.tmr_run     (tmr_run),
		.tmr_expired (tmr_expired),
		.data_valid  (data_valid),
		.cmd_mask    (cmd_mask),
		.data        (data),
		.data_ack    (data_ack),
		.cmd_done    (cmd_done),
		.cmd_abort   (cmd_abort),
		.state       (parser_state)
	);

	chan_cfg_bank u_bank (
		.clk        (clk),
		.rst_n      (rst_n),
		.data_valid (data_valid),
		.cmd_mask   (cmd_mask),
		.data       (data),
		.hold       (hold),
		.data_ack   (data_ack),
		.cfg        (cfg)
	);

endmodule

`default_nettype wire

//--- hw/recv_timer.sv
// Frame receive timer
// Down-counter loaded with the timeout, pulses expired when it runs out
`default_nettype none

module recv_timer
	import cmd_pkg::*;
(
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire logic load,
	input  wire logic run,
	output logic      expired
);

	logic [7:0] cnt;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			cnt     <= '0;
			expired <= 1'b0;
		end
		else if (load)
		begin
			cnt     <= 8'(RECV_TIMEOUT);
			expired <= 1'b0;
		end
		else if (run)
		begin
			cnt     <= cnt - 1'b1;
			expired <= (cnt == '0);    // Passing zero
		end
		else
			expired <= 1'b0;           // Frozen outside the wait
	end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build the command subsystem testbench with Verilator and run it.
# The run fails when the log holds the fail line.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -f src.f --top-module tb_cmd_subsys \
	-Mdir "$BUILD_DIR" -o sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if [ ! -s "$LOG" ]; then
	echo "Simulation log is empty"
	exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
	echo "Simulation reported a failure, see $LOG"
	exit 1
fi

echo "Simulation finished without failures"
exit 0

//--- src.f
hw/cmd_pkg.sv
hw/cmd_fifo.sv
hw/recv_timer.sv
hw/cmd_parser_fsm.sv
hw/chan_cfg_bank.sv
hw/cmd_subsys_top.sv
verification/tb_clkgen.sv
verification/tb_cmd_subsys.sv

//--- verification/tb_clkgen.sv
// Free-running clock source for the testbench
`default_nettype none

module tb_clkgen
#(
	parameter int PERIOD = 4
)
(
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD / 2) clk = ~clk;
	end

endmodule

`default_nettype wire

//--- verification/tb_cmd_subsys.sv
// Testbench for the command subsystem
// Frame stimulus, xorshift random source, cfg reference model,
// comparison process and cycle limit
`default_nettype none

module tb_cmd_subsys
	import cmd_pkg::*;
;

	localparam int MAX_TEST_LEN = 20;
	localparam int N_SINGLE     = 12;
	localparam int N_BURST      = 10;
	localparam int N_HOLD       = 10;
	localparam int N_FRAMES     = N_SINGLE + N_BURST + N_HOLD + 4 + 3;
	localparam int FRAME_WAIT   = (MAX_TEST_LEN + 3) * 16;    // Worst case gaps and hold
	localparam int CYCLE_LIMIT  = N_FRAMES * FRAME_WAIT + 2 * RECV_TIMEOUT + 4000;

	logic                  clk;
	logic                  rst_n;
	logic [7:0]            cmd_in;
	logic                  cmd_wr;
	logic                  hold;
	logic [NUM_CHAN*8-1:0] cfg;
	logic                  cmd_done;
	logic                  cmd_abort;
	parser_state_t         parser_state;

	logic [31:0]           rng_state = 32'd26993;
	logic [NUM_CHAN*8-1:0] model_cfg = '0;
	logic [NUM_CHAN*8-1:0] exp_cfg;
	logic                  check_req;
	logic [7:0]            frame_data [0:MAX_CMD_LEN];
	int done_seen   = 0;
	int abort_seen  = 0;
	int checks      = 0;
	int cmp_errors  = 0;
	int flow_errors = 0;
	int cycle_count = 0;

	tb_clkgen #(.PERIOD(4)) clk_src (.clk(clk));

	cmd_subsys_top dut0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.cmd_in       (cmd_in),
		.cmd_wr       (cmd_wr),
		.hold         (hold),
		.cfg          (cfg),
		.cmd_done     (cmd_done),
		.cmd_abort    (cmd_abort),
		.parser_state (parser_state)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic int pick_gap(input int max_gap);
		logic [31:0] r;
		r = next_random();
		return int'(r[7:0]) % (max_gap + 1);
	endfunction

	function automatic int error_total();
		return cmp_errors + flow_errors;
	endfunction

	// Masked channels end up with the last data byte, cut or rejected frames change nothing
	function automatic logic [NUM_CHAN*8-1:0] apply_frame_model(
		input  logic [NUM_CHAN*8-1:0] old_cfg,
		input  logic [7:0]            mask,
		input  int                    len,
		input  int                    sent,
		output logic                  ends_done
	);
		logic [NUM_CHAN*8-1:0] new_cfg;
		new_cfg   = old_cfg;
		ends_done = (len <= MAX_CMD_LEN) && (sent == len);
		if (ends_done && len > 0)
		begin
			for (int ch = 0; ch < NUM_CHAN; ch++)
			begin
				if (mask[ch])
					new_cfg[ch*8 +: 8] = frame_data[len-1];
			end
		end
		return new_cfg;
	endfunction

	task automatic fill_data(input int len, input logic avoid_magic);
		logic [31:0] r;
		for (int i = 0; i < len; i++)
		begin
			r = next_random();
			frame_data[i] = (avoid_magic && r[7:0] == CMD_MAGIC) ? 8'h55 : r[7:0];
		end
	endtask

	task automatic push_byte(input logic [7:0] b, input int gap);
		@(posedge clk);
		cmd_in <= b;
		cmd_wr <= 1'b1;
		repeat (gap)
		begin
			@(posedge clk);
			cmd_wr <= 1'b0;
		end
	endtask

	task automatic send_frame(input logic [7:0] mask, input int len, input int sent,
			input int max_gap);
		push_byte(CMD_MAGIC, pick_gap(max_gap));
		push_byte(8'(len), pick_gap(max_gap));
		if (len <= MAX_CMD_LEN)    // Oversized frames stop after the length byte
			push_byte(mask, pick_gap(max_gap));
		for (int i = 0; i < sent; i++)
			push_byte(frame_data[i], pick_gap(max_gap));
		@(posedge clk);
		cmd_wr <= 1'b0;
	endtask

	task automatic request_check();
		@(posedge clk);
		exp_cfg   <= model_cfg;
		check_req <= 1'b1;
		@(posedge clk);
		check_req <= 1'b0;
	endtask

	task automatic run_frame(input logic [7:0] mask, input int len, input int sent,
			input int max_gap, input logic hold_on, input int limit, output int cycles);
		logic        want_done;
		logic        got_done;
		logic        got_abort;
		logic [31:0] r;
		int          start_done;
		int          start_abort;
		start_done  = done_seen;
		start_abort = abort_seen;
		model_cfg   = apply_frame_model(model_cfg, mask, len, sent, want_done);
		send_frame(mask, len, sent, max_gap);
		cycles    = 0;
		got_done  = 1'b0;
		got_abort = 1'b0;
		while (!got_done && !got_abort && cycles < limit)
		begin
			@(posedge clk);
			r = next_random();
			hold <= hold_on & r[0];
			cycles++;
			got_done  = (done_seen != start_done);
			got_abort = (abort_seen != start_abort);
		end
		hold <= 1'b0;
		if (want_done && !got_done)
		begin
			$display("ERROR: frame of length %0d gave no cmd_done within %0d cycles",
				len, limit);
			flow_errors++;
		end
		if (!want_done && !got_abort)
		begin
			$display("ERROR: frame of length %0d with %0d data bytes gave no cmd_abort",
				len, sent);
			flow_errors++;
		end
		request_check();
		if ((done_seen - start_done) + (abort_seen - start_abort) > 1)
		begin
			$display("ERROR: frame of length %0d gave %0d cmd_done and %0d cmd_abort",
				len, done_seen - start_done, abort_seen - start_abort);
			flow_errors++;
		end
	endtask

	task automatic single_frames(input int count, input int max_gap, input logic hold_on);
		logic [31:0] r;
		int          len;
		int          cycles;
		for (int f = 0; f < count; f++)
		begin
			r   = next_random();
			len = int'(r[15:8]) % (MAX_TEST_LEN + 1);
			fill_data(len, 1'b0);
			run_frame(r[7:0], len, len, max_gap, hold_on, FRAME_WAIT, cycles);
		end
	endtask

	task automatic report_test(input int num, input string name, input int frames,
			input int err_mark);
		$display("[t%0d] %s: %0d frames, %s", num, name, frames,
			(error_total() == err_mark) ? "passed" : "failed");
	endtask

	// Comparison process, outputs sampled away from the active edge
	always @(negedge clk)
	begin
		if (rst_n && cmd_done)
			done_seen++;
		if (rst_n && cmd_abort)
			abort_seen++;
		if (check_req)
		begin
			checks++;
			if (cfg !== exp_cfg)
			begin
				$display("MISMATCH t=%0t cfg expected %h got %h", $time, exp_cfg, cfg);
				cmp_errors++;
			end
			if (parser_state !== ST_IDLE)
			begin
				$display("MISMATCH t=%0t parser_state expected %0d got %0d", $time,
					ST_IDLE, parser_state);
				cmp_errors++;
			end
		end
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT)
		begin
			$display("Run stopped after %0d cycles, a test did not finish", cycle_count);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial
	begin
		logic [31:0] r;
		logic [7:0]  mask;
		logic        want_done;
		int          len;
		int          sent;
		int          cycles;
		int          err_mark;
		int          start_count;
		int          abort_mark;
		rst_n     <= 1'b0;
		cmd_in    <= 8'h00;
		cmd_wr    <= 1'b0;
		hold      <= 1'b0;
		check_req <= 1'b0;
		exp_cfg   <= '0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;

		// Reset state, then noise without any magic byte
		err_mark = error_total();
		request_check();
		for (int i = 0; i < 32; i++)
		begin
			r = next_random();
			push_byte((r[7:0] == CMD_MAGIC) ? 8'h55 : r[7:0], 0);
		end
		@(posedge clk);
		cmd_wr <= 1'b0;
		repeat (40) @(posedge clk);
		if (done_seen != 0 || abort_seen != 0)
		begin
			$display("ERROR: cmd_done or cmd_abort seen while discarding noise bytes");
			flow_errors++;
		end
		request_check();
		report_test(1, "reset and noise", 0, err_mark);

		err_mark = error_total();
		single_frames(N_SINGLE, 0, 1'b0);
		report_test(2, "single frames", N_SINGLE, err_mark);

		// Frames queued without waiting, random gaps between bytes
		err_mark    = error_total();
		start_count = done_seen;
		abort_mark  = abort_seen;
		for (int f = 0; f < N_BURST; f++)
		begin
			r   = next_random();
			len = int'(r[15:8]) % (MAX_TEST_LEN + 1);
			fill_data(len, 1'b0);
			model_cfg = apply_frame_model(model_cfg, r[7:0], len, len, want_done);
			send_frame(r[7:0], len, len, 3);
		end
		cycles = 0;
		while (done_seen - start_count < N_BURST && cycles < N_BURST * FRAME_WAIT)
		begin
			@(posedge clk);
			cycles++;
		end
		if (done_seen - start_count != N_BURST || abort_seen != abort_mark)
		begin
			$display("ERROR: burst of %0d frames gave %0d cmd_done and %0d cmd_abort",
				N_BURST, done_seen - start_count, abort_seen - abort_mark);
			flow_errors++;
		end
		request_check();
		report_test(3, "back to back frames", N_BURST, err_mark);

		err_mark = error_total();
		single_frames(N_HOLD, 1, 1'b1);
		report_test(4, "frames under hold", N_HOLD, err_mark);

		// Cut frames, leftover bytes kept clear of the magic value
		err_mark = error_total();
		for (int f = 0; f < 2; f++)
		begin
			r    = next_random();
			len  = 1 + int'(r[15:8]) % MAX_TEST_LEN;
			sent = (f == 0) ? 0 : int'(r[23:16]) % len;
			mask = (r[7:0] == CMD_MAGIC) ? 8'h55 : r[7:0];
			fill_data(len, 1'b1);
			run_frame(mask, len, sent, 0, 1'b0, RECV_TIMEOUT + 32, cycles);
			// Timer starts before the mask, data bytes follow one per cycle
			if (cycles + sent < RECV_TIMEOUT - 4)
			begin
				$display("ERROR: cmd_abort came %0d cycles after the mask, before the timeout",
					cycles + sent);
				flow_errors++;
			end
			single_frames(1, 0, 1'b0);
		end
		report_test(5, "receive timeout", 4, err_mark);

		err_mark = error_total();
		for (int f = 0; f < 3; f++)
		begin
			r   = next_random();
			len = MAX_CMD_LEN + 1 + int'(r[15:8]) % (255 - MAX_CMD_LEN);
			run_frame(r[7:0], len, 0, 0, 1'b0, 16, cycles);
		end
		report_test(6, "oversized length", 3, err_mark);

		$display("summary: %0d checks, %0d errors, %0d cmd_done, %0d cmd_abort, %0d cycles",
			checks, error_total(), done_seen, abort_seen, cycle_count);
		if (error_total() == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire
